/* logic/spi_defs.svh */
// spi master register map and sizing macros, included by the rtl files that decode or size them
`ifndef SPI_DEFS_SVH
`define SPI_DEFS_SVH

// word offsets, matched against dstaddr[7:2]
`define SPI_CONFIG       6'h00   // spi_en, cpol, cpha, auto
`define SPI_STATUS       6'h01   // rx flag, state, busy
`define SPI_CLKDIV       6'h02   // half period = clkdiv+1 clk cycles
`define SPI_CMD          6'h03   // first byte on the wire
`define SPI_PSIZE        6'h04   // payload bytes after cmd
`define SPI_START        6'h05   // any write kicks a transfer
`define SPI_RX           6'h06   // last byte shifted in
`define SPI_TX           6'h08   // four words, 6'h08..6'h0b

// register reset values
`define SPI_CLKDIV_RESET 8'd4
`define SPI_PSIZE_RESET  8'd4

// transmit buffer depth in bytes
`define SPI_TX_BYTES     16

`endif

/* logic/spi_pkg.sv */
// shared types for the spi master, referenced by scoped name from the rtl files
package spi_pkg;

   // plain vectors with a meaning
   typedef logic [7:0]  spi_byte_t;   // cmd, psize, clkdiv, status, data
   typedef logic [31:0] spi_word_t;   // bus data and address
   typedef logic [1:0]  spi_dmode_t;  // 0 byte, 1 halfword, 2 word

   // single beat bus packet, used both ways
   typedef struct packed {
      logic       write;     // 1 = write, 0 = read / return
      spi_dmode_t datamode;  // selects write byte lanes
      spi_word_t  dstaddr;   // only bits 7:2 decoded
      spi_word_t  data;      // write data or read data
   } spi_packet_t;

   // what the serial engine needs from the registers
   typedef struct packed {
      logic      spi_en;  // engine enable
      logic      cpol;    // sclk idle level
      logic      cpha;    // 1 = sample on trailing edge
      spi_byte_t cmd;     // command byte, sent first
      spi_byte_t psize;   // buffer bytes after cmd
      spi_byte_t clkdiv;  // divider terminal count
   } spi_cfg_t;

   // engine fsm, also visible as status[3:1]
   typedef enum logic [2:0] {
      IDLE  = 3'd0,  // ss_n high, waiting for start
      SETUP = 3'd1,  // one half period before ss_n falls
      DATA  = 3'd2,  // clocking bytes
      HOLD  = 3'd3   // one half period before ss_n rises
   } spi_state_t;

endpackage

/* logic/spi_master_regs.sv */
// spi master register block: decodes bus packets, keeps the registers, returns reads, starts transfers
`timescale 1ns/1ps
`include "spi_defs.svh"

module spi_master_regs (
   input  logic                       clk,
   input  logic                       nreset,
   // bus request
   input  logic                       access_in,
   input  spi_pkg::spi_packet_t       packet_in,
   output logic                       wait_out,
   // bus return
   output logic                       access_out,
   output spi_pkg::spi_packet_t       packet_out,
   input  logic                       wait_in,
   // to engine
   output spi_pkg::spi_cfg_t          cfg,
   output logic [`SPI_TX_BYTES*8-1:0] tx_buf,
   output logic                       start,
   // from engine
   input  logic                       busy,
   input  spi_pkg::spi_state_t        state,
   input  logic                       rx_valid,
   input  spi_pkg::spi_byte_t         rx_byte
);

   localparam int         TX_WORDS = `SPI_TX_BYTES / 4;
   localparam logic [5:0] TX_BASE  = `SPI_TX;  // low two bits are zero

   logic               accept;      // request taken this edge
   logic               wr_en;
   logic               rd_en;
   logic [5:0]         addr_word;   // dstaddr[7:2]
   logic [1:0]         tx_sel;      // tx word within the buffer
   logic               is_tx;
   logic               tx_wr;
   logic               start_req;
   logic [3:0]         lane_en;     // byte lanes from datamode
   spi_pkg::spi_byte_t wbyte;       // lane 0 of write data
   spi_pkg::spi_word_t rdata;       // read mux result

   spi_pkg::spi_byte_t config_reg;
   spi_pkg::spi_byte_t cmd_reg;
   spi_pkg::spi_byte_t psize_reg;
   spi_pkg::spi_byte_t clkdiv_reg;
   spi_pkg::spi_byte_t rx_reg;
   logic               rx_flag;     // sticky, set by rx_valid
   spi_pkg::spi_word_t [TX_WORDS-1:0] tx_mem;

   //########################################################################
   // decode
   //########################################################################

   assign wait_out  = access_out & wait_in;  // one read in flight at most
   assign accept    = access_in & ~wait_out;
   assign wr_en     = accept & packet_in.write;
   assign rd_en     = accept & ~packet_in.write;
   assign addr_word = packet_in.dstaddr[7:2];
   assign tx_sel    = packet_in.dstaddr[3:2];
   assign is_tx     = (addr_word[5:2] == TX_BASE[5:2]);
   assign tx_wr     = wr_en & is_tx;
   assign wbyte     = packet_in.data[7:0];

   // manual start always, auto start on the lowest tx word
   assign start_req = wr_en & ((addr_word == `SPI_START) |
                               (config_reg[4] & is_tx & (tx_sel == 2'd0)));

   always_comb begin
      case (packet_in.datamode)
         2'd0:    lane_en = 4'b0001;  // byte
         2'd1:    lane_en = 4'b0011;  // halfword
         default: lane_en = 4'b1111;  // word
      endcase
   end

   //########################################################################
   // registers
   //########################################################################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         config_reg <= '0;
         cmd_reg    <= '0;
         psize_reg  <= `SPI_PSIZE_RESET;
         clkdiv_reg <= `SPI_CLKDIV_RESET;
      end else if (wr_en) begin
         case (addr_word)
            `SPI_CONFIG: config_reg <= wbyte;
            `SPI_CMD:    cmd_reg    <= wbyte;
            `SPI_PSIZE:  psize_reg  <= wbyte;
            `SPI_CLKDIV: clkdiv_reg <= wbyte;
            default:     ;
         endcase
      end
   end

   // status bit 0, cleared by any status write
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         rx_flag <= 1'b0;
      end else if (wr_en && addr_word == `SPI_STATUS) begin
         rx_flag <= 1'b0;
      end else if (rx_valid) begin
         rx_flag <= 1'b1;
      end
   end

   // start pulse one edge after acceptance, dropped while the engine runs
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         start <= 1'b0;
      end else begin
         start <= start_req & ~busy & ~start;  // ~start covers busy lag
      end
   end

   always_ff @(posedge clk) begin
      if (rx_valid) begin
         rx_reg <= rx_byte;
      end
   end

   // tx buffer, masked byte lanes
   always_ff @(posedge clk) begin
      if (tx_wr) begin
         for (int i = 0; i < 4; i++) begin
            if (lane_en[i]) begin
               tx_mem[tx_sel][i*8 +: 8] <= packet_in.data[i*8 +: 8];
            end
         end
      end
   end

   assign tx_buf = tx_mem;  // word 0 holds bytes 0..3

   assign cfg = '{spi_en: config_reg[0],
                  cpol:   config_reg[2],
                  cpha:   config_reg[3],
                  cmd:    cmd_reg,
                  psize:  psize_reg,
                  clkdiv: clkdiv_reg};

   //########################################################################
   // read return
   //########################################################################

   always_comb begin
      rdata = '0;
      if (is_tx) begin
         rdata = tx_mem[tx_sel];
      end else begin
         case (addr_word)
            `SPI_CONFIG: rdata[7:0] = config_reg;
            `SPI_STATUS: rdata[7:0] = {3'b000, busy, state, rx_flag};
            `SPI_CLKDIV: rdata[7:0] = clkdiv_reg;
            `SPI_CMD:    rdata[7:0] = cmd_reg;
            `SPI_PSIZE:  rdata[7:0] = psize_reg;
            `SPI_RX:     rdata[7:0] = rx_reg;
            default:     rdata      = '0;  // start and holes read zero
         endcase
      end
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         access_out <= 1'b0;
      end else if (rd_en) begin
         access_out <= 1'b1;
      end else if (!wait_in) begin
         access_out <= 1'b0;  // consumed
      end
   end

   // held return packet, only loaded on a new read
   always_ff @(posedge clk) begin
      if (rd_en) begin
         packet_out <= '{write:    1'b0,
                         datamode: packet_in.datamode,
                         dstaddr:  packet_in.dstaddr,
                         data:     rdata};
      end
   end

   // engine must not see a start while it is running
   a_start_not_busy: assert property (@(posedge clk) disable iff (!nreset)
      start |-> !busy);

   // a stalled return stays put
   a_return_held: assert property (@(posedge clk) disable iff (!nreset)
      access_out && wait_in |=> access_out && $stable(packet_out));

endmodule

/* logic/spi_master_io.sv */
// spi master serial engine: divider, slave select, shifters and byte sequencing for all four modes
`timescale 1ns/1ps
`include "spi_defs.svh"

module spi_master_io (
   input  logic                       clk,
   input  logic                       nreset,
   input  spi_pkg::spi_cfg_t          cfg,
   input  logic [`SPI_TX_BYTES*8-1:0] tx_buf,
   input  logic                       start,
   output logic                       busy,
   output spi_pkg::spi_state_t        state,
   output logic                       rx_valid,
   output spi_pkg::spi_byte_t         rx_byte,
   // spi pins
   output logic                       sclk,
   output logic                       mosi,
   output logic                       ss_n,
   input  logic                       miso
);

   spi_pkg::spi_byte_t div_cnt;        // half period counter
   logic               tick;           // half period boundary
   logic               in_data;
   logic [3:0]         edge_cnt;       // sclk edge within byte, even = leading
   logic [4:0]         byte_idx;       // 0 = cmd, n = buffer byte n-1
   logic [4:0]         last_idx;       // latched at start
   logic [4:0]         psize_clamped;
   logic               sample_now;
   logic               shift_now;
   logic               byte_end;
   spi_pkg::spi_byte_t next_byte;
   spi_pkg::spi_byte_t tx_shift;
   spi_pkg::spi_byte_t rx_shift;

   //########################################################################
   // timing and edge selection
   //########################################################################

   assign tick    = (div_cnt == cfg.clkdiv);
   assign in_data = (state == spi_pkg::DATA);
   assign busy    = (state != spi_pkg::IDLE);

   // more than a full buffer makes no sense
   assign psize_clamped = (cfg.psize > `SPI_TX_BYTES) ? 5'(`SPI_TX_BYTES) : cfg.psize[4:0];

   // cpha 0 samples leading edges, cpha 1 trailing edges
   assign sample_now = in_data & tick & (edge_cnt[0] == cfg.cpha);

   // launch on the other edge, first and last of a byte excluded
   assign shift_now  = in_data & tick & (edge_cnt[0] != cfg.cpha) &
                       (edge_cnt != 4'd15) & (edge_cnt != 4'd0);

   assign byte_end   = in_data & tick & (edge_cnt == 4'd15);

   // buffer byte that follows the one now finishing
   assign next_byte  = tx_buf[{byte_idx[3:0], 3'b000} +: 8];

   assign mosi = in_data & tx_shift[7];  // low outside data phase

   //########################################################################
   // fsm
   //########################################################################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         state    <= spi_pkg::IDLE;
         ss_n     <= 1'b1;
         sclk     <= 1'b0;
         div_cnt  <= '0;
         edge_cnt <= '0;
         byte_idx <= '0;
         last_idx <= '0;
         rx_valid <= 1'b0;
      end else begin
         rx_valid <= cfg.spi_en & sample_now & (edge_cnt[3:1] == 3'd7);  // 8th bit in
         if (!cfg.spi_en) begin
            // disabled, park everything
            state   <= spi_pkg::IDLE;
            ss_n    <= 1'b1;
            sclk    <= cfg.cpol;
            div_cnt <= '0;
         end else begin
            div_cnt <= (state == spi_pkg::IDLE || tick) ? 8'd0 : div_cnt + 8'd1;
            case (state)
               spi_pkg::IDLE: begin
                  sclk <= cfg.cpol;  // track idle level
                  if (start) begin
                     state    <= spi_pkg::SETUP;
                     last_idx <= psize_clamped;
                  end
               end
               spi_pkg::SETUP: begin
                  sclk <= cfg.cpol;
                  if (tick) begin
                     state    <= spi_pkg::DATA;
                     ss_n     <= 1'b0;  // select slave
                     edge_cnt <= '0;
                     byte_idx <= '0;
                  end
               end
               spi_pkg::DATA: begin
                  if (tick) begin
                     sclk     <= ~sclk;
                     edge_cnt <= edge_cnt + 4'd1;  // wraps per byte
                     if (edge_cnt == 4'd15) begin
                        if (byte_idx == last_idx) begin
                           state <= spi_pkg::HOLD;
                        end else begin
                           byte_idx <= byte_idx + 5'd1;
                        end
                     end
                  end
               end
               spi_pkg::HOLD: begin
                  sclk <= cfg.cpol;
                  if (tick) begin
                     state <= spi_pkg::IDLE;
                     ss_n  <= 1'b1;  // deselect, busy drops
                  end
               end
               default: state <= spi_pkg::IDLE;
            endcase
         end
      end
   end

   //########################################################################
   // shifters
   //########################################################################

   always_ff @(posedge clk) begin
      if (state == spi_pkg::SETUP && tick) begin
         tx_shift <= cfg.cmd;  // cmd goes first
      end else if (byte_end && byte_idx != last_idx) begin
         tx_shift <= next_byte;
      end else if (shift_now) begin
         tx_shift <= {tx_shift[6:0], 1'b0};  // msb first
      end
      if (sample_now) begin
         rx_shift <= {rx_shift[6:0], miso};
      end
      if (sample_now && edge_cnt[3:1] == 3'd7) begin
         rx_byte <= {rx_shift[6:0], miso};  // full byte incl. this bit
      end
   end

   // slave never selected while idle
   a_idle_deselected: assert property (@(posedge clk) disable iff (!nreset)
      state == spi_pkg::IDLE |-> ss_n);

   // sclk rests at cpol whenever the slave is deselected
   a_sclk_idle_level: assert property (@(posedge clk) disable iff (!nreset)
      ss_n && $stable(cfg.cpol) |-> sclk == cfg.cpol);

endmodule

/* logic/spi_master.sv */
// spi master top, joins the register block and the serial engine to the bus and the spi pins
`timescale 1ns/1ps
`include "spi_defs.svh"

module spi_master (
   input  logic                 clk,
   input  logic                 nreset,
   // bus request
   input  logic                 access_in,
   input  spi_pkg::spi_packet_t packet_in,
   output logic                 wait_out,
   // bus return
   output logic                 access_out,
   output spi_pkg::spi_packet_t packet_out,
   input  logic                 wait_in,
   // spi pins
   output logic                 sclk,
   output logic                 mosi,
   input  logic                 miso,
   output logic                 ss_n
);

   spi_pkg::spi_cfg_t           cfg;
   logic [`SPI_TX_BYTES*8-1:0]  tx_buf;
   logic                        start;     // one cycle
   logic                        busy;
   spi_pkg::spi_state_t         state;
   logic                        rx_valid;  // one cycle per byte
   spi_pkg::spi_byte_t          rx_byte;

   spi_master_regs u_regs (
      .clk        (clk),
      .nreset     (nreset),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in),
      .cfg        (cfg),
      .tx_buf     (tx_buf),
      .start      (start),
      .busy       (busy),
      .state      (state),
      .rx_valid   (rx_valid),
      .rx_byte    (rx_byte)
   );

   spi_master_io u_io (
      .clk      (clk),
      .nreset   (nreset),
      .cfg      (cfg),
      .tx_buf   (tx_buf),
      .start    (start),
      .busy     (busy),
      .state    (state),
      .rx_valid (rx_valid),
      .rx_byte  (rx_byte),
      .sclk     (sclk),
      .mosi     (mosi),
      .ss_n     (ss_n),
      .miso     (miso)
   );

endmodule

/* tb/spi_master_checker.sv */
// spi master checker: decodes mosi frames and bus returns and compares them with expected values
`timescale 1ns/1ps
`include "spi_defs.svh"

module spi_master_checker (
   input  logic                       clk,
   input  logic                       nreset,
   // watched dut pins
   input  logic                       sclk,
   input  logic                       mosi,
   input  logic                       ss_n,
   input  logic                       access_out,
   input  logic                       wait_in,
   input  spi_pkg::spi_packet_t       packet_out,
   // mirrored expectations from the testbench
   input  logic                       cpol,
   input  logic                       cpha,
   input  spi_pkg::spi_byte_t         exp_cmd,
   input  spi_pkg::spi_byte_t         exp_psize,
   input  logic [`SPI_TX_BYTES*8-1:0] exp_buf,
   input  spi_pkg::spi_word_t         exp_rdata,
   output int                         errors,
   output int                         frames,
   output int                         returns
);

   int                 frame_err = 0;
   int                 ret_err = 0;
   int                 frame_cnt = 0;
   int                 ret_cnt = 0;
   int                 nbits = 0;
   logic               sclk_q = 1'b0;   // pin values at previous negedge
   logic               mosi_q = 1'b0;
   logic               ss_q = 1'b1;
   spi_pkg::spi_byte_t shreg;
   spi_pkg::spi_byte_t got[$];         // bytes of the current frame

   assign errors  = frame_err + ret_err;
   assign frames  = frame_cnt;
   assign returns = ret_cnt;

   // reference: cmd first, then buffer bytes lowest first
   function automatic spi_pkg::spi_byte_t expected_byte(input int idx,
         input spi_pkg::spi_byte_t cmd, input logic [`SPI_TX_BYTES*8-1:0] tx);
      if (idx == 0) begin
         return cmd;
      end
      return tx[(idx-1)*8 +: 8];
   endfunction

   function automatic int expected_len(input spi_pkg::spi_byte_t psize);
      int n;
      n = (psize > `SPI_TX_BYTES) ? `SPI_TX_BYTES : int'(psize);  // clamp
      return n + 1;
   endfunction

   task automatic compare_frame();
      int len;
      len = expected_len(exp_psize);
      if (got.size() != len || nbits != 0) begin
         $display("frame length wrong at %0t: expected %0d bytes, got %0d bytes and %0d bits",
                  $time, len, got.size(), nbits);
         frame_err++;
      end
      for (int i = 0; i < got.size() && i < len; i++) begin
         if (got[i] !== expected_byte(i, exp_cmd, exp_buf)) begin
            $display("ERR %0t mosi_byte[%0d] expected %02h actual %02h",
                     $time, i, expected_byte(i, exp_cmd, exp_buf), got[i]);
            frame_err++;
         end
      end
      frame_cnt++;
   endtask

   //########################################################################
   // mosi decode, edges seen one negedge late so mosi_q is pre-edge data
   //########################################################################

   always @(negedge clk) begin
      if (nreset) begin
         if (ss_q && !ss_n) begin  // frame opens
            nbits = 0;
            got.delete();
         end
         // sampling edge: leading for cpha 0, trailing for cpha 1
         if (!ss_q && !ss_n && sclk != sclk_q && ((sclk != cpol) == !cpha)) begin
            shreg = {shreg[6:0], mosi_q};  // msb first
            nbits++;
            if (nbits == 8) begin
               got.push_back(shreg);
               nbits = 0;
            end
         end
         if (!ss_q && ss_n) begin
            compare_frame();
         end
      end
      sclk_q = sclk;
      mosi_q = mosi;
      ss_q   = ss_n;
   end

   //########################################################################
   // bus returns, checked on the consuming edge
   //########################################################################

   always @(posedge clk) begin
      if (nreset && access_out && !wait_in) begin
         ret_cnt++;
         if (packet_out.data !== exp_rdata) begin
            $display("ERR %0t packet_out.data expected %08h actual %08h",
                     $time, exp_rdata, packet_out.data);
            ret_err++;
         end
         if (packet_out.write !== 1'b0) begin
            $display("ERR %0t packet_out.write expected 0 actual %0b", $time, packet_out.write);
            ret_err++;
         end
      end
   end

endmodule

/* tb/spi_master_tb.sv */
// spi master testbench top: clock, reset, bus driver, miso loopback and the closing report
`timescale 1ns/1ps
`include "spi_defs.svh"

module spi_master_tb;

   localparam int TIMEOUT = 10000;  // negedges allowed per wait

   logic                 clk = 1'b0;
   logic                 nreset;
   logic                 access_in;
   spi_pkg::spi_packet_t packet_in;
   logic                 wait_out;
   logic                 access_out;
   spi_pkg::spi_packet_t packet_out;
   logic                 wait_in;
   logic                 sclk;
   logic                 mosi;
   logic                 miso;
   logic                 ss_n;

   // register mirrors
   spi_pkg::spi_byte_t   cfg_m;
   spi_pkg::spi_byte_t   cmd_m;
   spi_pkg::spi_byte_t   psize_m;
   spi_pkg::spi_byte_t   clkdiv_m;
   logic [`SPI_TX_BYTES*8-1:0] buf_m;
   spi_pkg::spi_word_t   exp_rdata;
   spi_pkg::spi_packet_t held_pkt;

   logic [31:0] lcg_state = 32'd7;
   int          tb_err = 0;
   int          chk_err;
   int          chk_frames;
   int          chk_returns;
   int          xfers = 0;  // starts issued, manual or auto
   event        abort_ev;

   always #50 clk = ~clk;
   assign miso = mosi;  // loopback

   spi_master UUT (.clk(clk), .nreset(nreset), .access_in(access_in), .packet_in(packet_in),
      .wait_out(wait_out), .access_out(access_out), .packet_out(packet_out),
      .wait_in(wait_in), .sclk(sclk), .mosi(mosi), .miso(miso), .ss_n(ss_n));

   spi_master_checker u_checker (.clk(clk), .nreset(nreset), .sclk(sclk), .mosi(mosi),
      .ss_n(ss_n), .access_out(access_out), .wait_in(wait_in), .packet_out(packet_out),
      .cpol(cfg_m[2]), .cpha(cfg_m[3]), .exp_cmd(cmd_m), .exp_psize(psize_m),
      .exp_buf(buf_m), .exp_rdata(exp_rdata), .errors(chk_err), .frames(chk_frames),
      .returns(chk_returns));

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return {lcg_state[15:0], lcg_state[31:16]};  // upper bits are the better ones
   endfunction

   task automatic give_up(input string why);
      $display("timeout at %0t: %s", $time, why);
      -> abort_ev;
   endtask

   // one bus beat, driven on the falling edge once wait_out is low
   task automatic bus_send(input logic wr, input logic [1:0] mode, input logic [5:0] word,
                           input logic [31:0] data);
      int n;
      n = 0;
      while (wait_out && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (wait_out) give_up("request never accepted, wait_out stuck high");
      packet_in = '{write: wr, datamode: mode, dstaddr: {24'h0, word, 2'b00}, data: data};
      access_in = 1'b1;
      @(negedge clk);
      access_in = 1'b0;
   endtask

   task automatic reg_write(input logic [5:0] word, input logic [31:0] data);
      bus_send(1'b1, 2'd2, word, data);
   endtask

   // expected value goes to the checker, which compares on consumption
   task automatic reg_read(input logic [5:0] word, input logic [31:0] expect_val);
      int n;
      n = 0;
      exp_rdata = expect_val;
      bus_send(1'b0, 2'd2, word, 32'h0);
      while (!access_out && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (!access_out) give_up("read return never arrived");
      if (!wait_in) @(negedge clk);  // consumed on this edge
   endtask

   task automatic tx_write(input int k, input logic [1:0] mode, input logic [31:0] data);
      logic [3:0] lanes;
      lanes = (mode == 2'd0) ? 4'b0001 : (mode == 2'd1) ? 4'b0011 : 4'b1111;
      for (int i = 0; i < 4; i++) begin
         if (lanes[i]) buf_m[k*32 + i*8 +: 8] = data[i*8 +: 8];
      end
      bus_send(1'b1, mode, 6'(`SPI_TX + k), data);
   endtask

   // ss_n low then high again marks one whole transfer
   task automatic wait_transfer();
      int n;
      n = 0;
      while (ss_n && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (ss_n) give_up("ss_n never fell after start");
      n = 0;
      while (!ss_n && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (!ss_n) give_up("transfer never ended, ss_n stuck low");
      @(negedge clk);
   endtask

   task automatic load_random();
      cmd_m   = lcg_next() & 8'hff;
      psize_m = 8'((lcg_next() % 16) + 1);
      reg_write(`SPI_CMD, {24'h0, cmd_m});
      reg_write(`SPI_PSIZE, {24'h0, psize_m});
      for (int k = 3; k >= 1; k--) tx_write(k, 2'd2, lcg_next());
   endtask

   task automatic check_sclk_idle();
      if (sclk !== cfg_m[2]) begin
         $display("ERR %0t sclk expected %0b actual %0b", $time, cfg_m[2], sclk);
         tb_err++;
      end
      if (ss_n !== 1'b1) begin
         $display("ERR %0t ss_n expected 1 actual %0b", $time, ss_n);
         tb_err++;
      end
   endtask

   initial begin
      @(abort_ev);
      $display("errors: checker %0d, testbench %0d", chk_err, tb_err);
      $display("test failed");
      $finish;
   end

   initial begin : stimulus
      nreset = 1'b0;
      access_in = 1'b0;
      packet_in = '0;
      wait_in = 1'b0;
      exp_rdata = '0;
      cfg_m = 8'h00;
      cmd_m = 8'h00;
      psize_m = `SPI_PSIZE_RESET;
      clkdiv_m = `SPI_CLKDIV_RESET;
      buf_m = '0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      nreset = 1'b1;
      @(negedge clk);

      // reset values
      reg_read(`SPI_CONFIG, 32'h0);
      reg_read(`SPI_STATUS, 32'h0);
      reg_read(`SPI_CLKDIV, 32'd4);
      reg_read(`SPI_PSIZE, 32'd4);
      check_sclk_idle();

      // masked lanes on every tx word
      for (int k = 0; k < 4; k++) begin
         tx_write(k, 2'd2, lcg_next());
         tx_write(k, 2'd1, lcg_next());
         tx_write(k, 2'd0, lcg_next());
         reg_read(6'(`SPI_TX + k), buf_m[k*32 +: 32]);
      end

      // manual start, all modes, two divider values
      for (int d = 0; d < 2; d++) begin
         clkdiv_m = (d == 0) ? 8'd0 : 8'd3;
         reg_write(`SPI_CLKDIV, {24'h0, clkdiv_m});
         for (int m = 0; m < 4; m++) begin
            cfg_m = {4'b0000, 1'(m >> 1), 1'(m), 2'b01};  // cpha, cpol, en
            reg_write(`SPI_CONFIG, {24'h0, cfg_m});
            load_random();
            tx_write(0, 2'd2, lcg_next());
            repeat (2) @(negedge clk);
            check_sclk_idle();
            reg_write(`SPI_START, 32'h1);
            xfers++;
            wait_transfer();
            check_sclk_idle();
         end
      end

      // auto start by the lowest tx word, rx through loopback
      cfg_m = 8'h11;
      reg_write(`SPI_CONFIG, {24'h0, cfg_m});
      reg_write(`SPI_STATUS, 32'h0);  // drop the flag left by manual transfers
      load_random();
      tx_write(0, 2'd2, lcg_next());
      xfers++;
      wait_transfer();
      reg_read(`SPI_RX, {24'h0, buf_m[(psize_m-1)*8 +: 8]});
      reg_read(`SPI_STATUS, 32'h1);
      reg_write(`SPI_STATUS, 32'h0);
      reg_read(`SPI_STATUS, 32'h0);

      // stalled return
      wait_in = 1'b1;
      fork
         reg_read(`SPI_CLKDIV, {24'h0, clkdiv_m});
      join_none
      repeat (3) @(negedge clk);
      held_pkt = packet_out;
      repeat (5) begin
         @(negedge clk);
         if (access_out !== 1'b1) begin
            $display("ERR %0t access_out expected 1 actual %0b", $time, access_out);
            tb_err++;
         end
         if (wait_out !== 1'b1) begin
            $display("ERR %0t wait_out expected 1 actual %0b", $time, wait_out);
            tb_err++;
         end
         if (packet_out !== held_pkt) begin
            $display("ERR %0t packet_out expected %h actual %h", $time, held_pkt, packet_out);
            tb_err++;
         end
      end
      wait_in = 1'b0;
      repeat (3) @(negedge clk);

      if (chk_frames != xfers) begin
         $display("checker saw %0d transfers, %0d were started", chk_frames, xfers);
         tb_err++;
      end
      $display("errors: checker %0d, testbench %0d, frames %0d, returns %0d",
               chk_err, tb_err, chk_frames, chk_returns);
      if (chk_err == 0 && tb_err == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

/* sim.f */
+incdir+logic
logic/spi_pkg.sv
logic/spi_master_regs.sv
logic/spi_master_io.sv
logic/spi_master.sv
tb/spi_master_checker.sv
tb/spi_master_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the spi master testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
   --top-module spi_master_tb \
   -f sim.f \
   -o spi_sim

./obj_dir/spi_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "test passed" sim.log; then
   exit 0
else
   exit 1
fi
